// File: design/alu.sv
`timescale 1ns/1ns

module alu (
    input  ctrlPkg::ctrlWordT            ctrl,
    input  logic [isaPkg::DataWidth-1:0] opA,
    input  logic [isaPkg::DataWidth-1:0] opB,
    output logic [isaPkg::DataWidth-1:0] result
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [ShiftBits-1:0]   shAmt;
    logic [2*DataWidth-1:0] rolWide, rorWide;
    logic [DataWidth-1:0]   addIn, sum;
    logic                   overflow, negative, zero;

    assign shAmt   = opB[ShiftBits-1:0];
    assign rolWide = {opA, opA} << shAmt;
    assign rorWide = {opA, opA} >> shAmt;

    // subtraction in this ISA is B minus A, so the inversion applies to opA.
    assign addIn    = opA ^ {DataWidth{ctrl.invB}};
    assign sum      = opB + addIn + DataWidth'(ctrl.cin);
    assign overflow = (opB[DataWidth-1] == addIn[DataWidth-1]) &&
                      (sum[DataWidth-1] != opB[DataWidth-1]);
    assign negative = sum[DataWidth-1] ^ overflow;   // true sign of B minus A.
    assign zero     = (sum == '0);

    always_comb begin
        case (ctrl.aluOp)
            AluRol:  result = rolWide[2*DataWidth-1:DataWidth];
            AluSll:  result = opA << shAmt;
            AluRor:  result = rorWide[DataWidth-1:0];
            AluSrl:  result = opA >> shAmt;
            AluAdd:  result = sum;
            AluXor:  result = opA ^ opB;
            AluAndn: result = opA & ~opB;
            AluSeq:  result = DataWidth'(zero);
            AluSlt:  result = DataWidth'(!negative && !zero); // A below B means B-A is positive.
            AluSle:  result = DataWidth'(!negative);
            default: result = '0;
        endcase
    end

    always_comb begin
        aluOpDefined: assert final (ctrl.aluOp inside {AluRol, AluSll, AluRor, AluSrl, AluAdd,
                                                       AluXor, AluAndn, AluSeq, AluSlt, AluSle})
            else $error("undefined ALU operation %0d", ctrl.aluOp);
    end

endmodule

// File: design/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  isaPkg::opcodeT    opcode,
    input  logic [1:0]        func,
    output ctrlPkg::ctrlWordT ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    // the two low select bits order the shifts the same way in both forms.
    function automatic aluOpT shiftOp(input logic [1:0] sel);
        case (sel)
            2'b00:   return AluRol;
            2'b01:   return AluSll;
            2'b10:   return AluRor;
            default: return AluSrl;
        endcase
    endfunction

    function automatic ctrlWordT withArith(input ctrlWordT base, input logic [1:0] sel);
        ctrlWordT c;
        c = base;
        case (sel)
            2'b00: c.aluOp = AluAdd;
            2'b01: begin
                c.aluOp = AluAdd;
                c.invB  = 1'b1;                      // subtract.
                c.cin   = 1'b1;
            end
            2'b10:   c.aluOp = AluXor;
            default: c.aluOp = AluAndn;
        endcase
        return c;
    endfunction

    always_comb begin
        ctrl          = '0;
        ctrl.aluOp    = AluAdd;
        ctrl.immFmt   = ImmNone;
        ctrl.writeSel = WrRd;
        case (opcode)
            OpHalt: ctrl.halt = 1'b1;
            OpNop: begin
            end
            OpRtype: begin
                ctrl.regWrite = 1'b1;
                case (func)
                    2'b00:   ctrl = withArith(ctrl, 2'b00);
                    2'b01:   ctrl = withArith(ctrl, 2'b01);
                    2'b10:   ctrl = withArith(ctrl, 2'b10);
                    default: ctrl = withArith(ctrl, 2'b11);
                endcase
            end
            OpShift: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = shiftOp(func);
            end
            OpAddi, OpSubi, OpXori, OpAndni: begin
                ctrl          = withArith(ctrl, opcode[1:0]);
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeSel = WrRt;
                ctrl.immFmt   = opcode[1] ? ImmZext5 : ImmSext5; // logic forms zero-extend.
            end
            OpRoli, OpSlli, OpRori, OpSrli: begin
                ctrl.aluOp    = shiftOp(opcode[1:0]);
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeSel = WrRt;
                ctrl.immFmt   = ImmZext5;
            end
            OpSeq, OpSlt, OpSle: begin
                ctrl.regWrite = 1'b1;
                ctrl.invB     = 1'b1;
                ctrl.cin      = 1'b1;
                ctrl.aluOp    = (opcode == OpSeq) ? AluSeq :
                                (opcode == OpSlt) ? AluSlt : AluSle;
            end
            OpSlbi: begin
                ctrl.aluOp    = AluXor;              // low byte of the shifted rs is zero.
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeSel = WrRs;
                ctrl.immFmt   = ImmZext8;
                ctrl.slbi     = 1'b1;
            end
            OpLbi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeSel = WrRs;
                ctrl.immFmt   = ImmSext8;
                ctrl.lbi      = 1'b1;
            end
            OpLd: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeSel = WrRt;
                ctrl.immFmt   = ImmSext5;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            OpSt: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.writeSel = WrRt;
                ctrl.immFmt   = ImmSext5;
                ctrl.memWrite = 1'b1;
            end
            OpJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.writeSel = WrLink;
                ctrl.link     = 1'b1;
            end
            default: ctrl.exception = 1'b1;          // no write and no memory access.
        endcase
    end

endmodule

// File: design/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [3:0] {
        AluRol  = 4'd0,
        AluSll  = 4'd1,
        AluRor  = 4'd2,
        AluSrl  = 4'd3,
        AluAdd  = 4'd4,
        AluXor  = 4'd5,
        AluAndn = 4'd6,
        AluSeq  = 4'd7,
        AluSlt  = 4'd8,
        AluSle  = 4'd9
    } aluOpT;

    typedef enum logic [2:0] {
        ImmNone  = 3'd0,
        ImmSext5 = 3'd1,
        ImmZext5 = 3'd2,
        ImmSext8 = 3'd3,
        ImmZext8 = 3'd4
    } immFmtT;

    // which instruction field names the destination register.
    typedef enum logic [1:0] {
        WrRs   = 2'd0,
        WrRt   = 2'd1,
        WrRd   = 2'd2,
        WrLink = 2'd3
    } writeSelT;

    typedef struct packed {
        aluOpT    aluOp;
        immFmtT   immFmt;
        writeSelT writeSel;
        logic     aluSrc;                            // operand B is the immediate.
        logic     invB;
        logic     cin;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        logic     slbi;
        logic     lbi;
        logic     link;
        logic     halt;
        logic     exception;
    } ctrlWordT;

endpackage

// File: design/decode.sv
`timescale 1ns/1ns

module decode (
    input  logic                         clk,
    input  logic                         reset,
    input  isaPkg::instrT                instr,
    input  logic [isaPkg::DataWidth-1:0] writeData,
    input  logic [isaPkg::DataWidth-1:0] incPc,
    output ctrlPkg::ctrlWordT            ctrl,
    output logic [isaPkg::DataWidth-1:0] opA,
    output logic [isaPkg::DataWidth-1:0] opB,
    output logic [isaPkg::DataWidth-1:0] storeData,
    output logic                         err
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [RegSelWidth-1:0] writeReg;
    logic [DataWidth-1:0]   rfWriteData, rsData, rtData, imm;
    logic [Imm5Width-1:0]   imm5;
    logic [Imm8Width-1:0]   imm8;
    logic                   fmtErr;

    controlUnit uCtrl (
        .opcode (instr.opcode),
        .func   (instr.func),
        .ctrl   (ctrl)
    );

    assign rfWriteData = ctrl.link ? incPc : writeData;

    registerFile uRegs (
        .clk       (clk),
        .reset     (reset),
        .readSel1  (instr.rs),
        .readSel2  (instr.rt),
        .writeSel  (writeReg),
        .write     (ctrl.regWrite),
        .writeData (rfWriteData),
        .readData1 (rsData),
        .readData2 (rtData)
    );

    always_comb begin
        case (ctrl.writeSel)
            WrRs:    writeReg = instr.rs;
            WrRt:    writeReg = instr.rt;
            WrRd:    writeReg = instr.rd;
            default: writeReg = RegSelWidth'(LinkReg);
        endcase
    end

    assign imm5 = {instr.rd, instr.func};
    assign imm8 = {instr.rt, instr.rd, instr.func};

    always_comb begin
        case (ctrl.immFmt)
            ImmSext5: imm = {{(DataWidth - Imm5Width){imm5[Imm5Width-1]}}, imm5};
            ImmZext5: imm = {{(DataWidth - Imm5Width){1'b0}}, imm5};
            ImmSext8: imm = {{(DataWidth - Imm8Width){imm8[Imm8Width-1]}}, imm8};
            ImmZext8: imm = {{(DataWidth - Imm8Width){1'b0}}, imm8};
            default:  imm = '0;
        endcase
    end

    // LBI adds its immediate to zero, SLBI merges it under the shifted rs.
    assign opA = ctrl.lbi ? '0 : (ctrl.slbi ? (rsData << Imm8Width) : rsData);
    assign opB = ctrl.aluSrc ? imm : rtData;
    assign storeData = rtData;

    // an immediate width has to agree with the field that names the destination.
    assign fmtErr = ((ctrl.immFmt inside {ImmSext8, ImmZext8}) && (ctrl.writeSel != WrRs)) ||
                    ((ctrl.immFmt inside {ImmSext5, ImmZext5}) && (ctrl.writeSel != WrRt)) ||
                    (ctrl.link && (ctrl.writeSel != WrLink));
    assign err = ctrl.exception | fmtErr;

    errKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(err))
        else $error("err is unknown");
    fmtConsistent: assert property (@(posedge clk) disable iff (reset) !fmtErr)
        else $error("control word pairs immediate %s with write select %s",
                    ctrl.immFmt.name(), ctrl.writeSel.name());

endmodule

// File: design/execCore.sv
`timescale 1ns/1ns

module execCore (
    input  logic                         clk,
    input  logic                         reset,
    input  isaPkg::instrT                instr,
    input  logic [isaPkg::DataWidth-1:0] incPc,
    input  logic [isaPkg::DataWidth-1:0] loadData,
    output logic [isaPkg::DataWidth-1:0] aluResult,
    output logic [isaPkg::DataWidth-1:0] storeData,
    output logic                         memRead,
    output logic                         memWrite,
    output logic                         halt,
    output logic                         err
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlWordT             ctrl;
    logic [DataWidth-1:0] opA, opB, writeData;

    decode uDecode (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .writeData (writeData),
        .incPc     (incPc),
        .ctrl      (ctrl),
        .opA       (opA),
        .opB       (opB),
        .storeData (storeData),
        .err       (err)
    );

    alu uAlu (
        .ctrl   (ctrl),
        .opA    (opA),
        .opB    (opB),
        .result (aluResult)
    );

    assign writeData = ctrl.memToReg ? loadData : aluResult; // loads write the memory data.
    assign memRead   = ctrl.memRead;
    assign memWrite  = ctrl.memWrite;
    assign halt      = ctrl.halt;

endmodule

// File: design/isaPkg.sv
package isaPkg;

    localparam int DataWidth   = 16;
    localparam int RegCount    = 8;
    localparam int RegSelWidth = $clog2(RegCount);
    localparam int LinkReg     = 7;                  // JAL writes its return address here.
    localparam int Imm5Width   = 5;
    localparam int Imm8Width   = 8;                  // also the SLBI shift distance.
    localparam int ShiftBits   = $clog2(DataWidth);

    // major opcodes, bits [15:11] of every instruction.
    typedef enum logic [4:0] {
        OpHalt  = 5'b00000,
        OpNop   = 5'b00001,
        OpJal   = 5'b00110,
        OpAddi  = 5'b01000,
        OpSubi  = 5'b01001,
        OpXori  = 5'b01010,
        OpAndni = 5'b01011,
        OpSt    = 5'b10000,
        OpLd    = 5'b10001,
        OpSlbi  = 5'b10010,
        OpRoli  = 5'b10100,
        OpSlli  = 5'b10101,
        OpRori  = 5'b10110,
        OpSrli  = 5'b10111,
        OpLbi   = 5'b11000,
        OpShift = 5'b11010,                          // ROL/SLL/ROR/SRL chosen by func.
        OpRtype = 5'b11011,                          // ADD/SUB/XOR/ANDN chosen by func.
        OpSeq   = 5'b11100,
        OpSlt   = 5'b11101,
        OpSle   = 5'b11110
    } opcodeT;

    // the 5-bit immediate is {rd, func} and the 8-bit one is {rt, rd, func}.
    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } instrT;

endpackage

// File: design/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [isaPkg::RegSelWidth-1:0] readSel1,
    input  logic [isaPkg::RegSelWidth-1:0] readSel2,
    input  logic [isaPkg::RegSelWidth-1:0] writeSel,
    input  logic                           write,
    input  logic [isaPkg::DataWidth-1:0]   writeData,
    output logic [isaPkg::DataWidth-1:0]   readData1,
    output logic [isaPkg::DataWidth-1:0]   readData2
);
    import isaPkg::*;

    logic [RegCount-1:0][DataWidth-1:0] regs;

    // reset takes priority, so a write strobe during reset is dropped.
    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (write) begin
            regs[writeSel] <= writeData;
        end
    end

    // reads are not bypassed, so the written value shows up a cycle later.
    assign readData1 = regs[readSel1];
    assign readData2 = regs[readSel2];

    // the write strobe stays low for as long as reset is held.
    noWriteInReset: assert property (@(posedge clk) reset |-> !write)
        else $error("write strobe raised during reset");

endmodule

// File: tests/execCoreRef.svh
`ifndef EXEC_CORE_REF_SVH
`define EXEC_CORE_REF_SVH

typedef struct packed {
    logic [15:0] result;
    logic [15:0] storeData;
    logic [15:0] writeData;
    logic [2:0]  writeReg;
    logic        checkResult;                        // aluResult is only defined for ALU users.
    logic        write;
    logic        memRead;
    logic        memWrite;
    logic        halt;
    logic        err;
} expectT;

logic [15:0] shadowRegs [8];

function automatic logic [15:0] arithOf(input logic [1:0] sel, input logic [15:0] a, b);
    case (sel)
        2'b00:   return a + b;
        2'b01:   return b - a;                       // SUB takes rs away from the other operand.
        2'b10:   return a ^ b;
        default: return a & ~b;
    endcase
endfunction

function automatic logic [15:0] shiftOf(input logic [1:0] sel, input logic [15:0] a,
                                        input logic [3:0] n);
    case (sel)
        2'b00:   return (a << n) | (a >> (16 - n));
        2'b01:   return a << n;
        2'b10:   return (a >> n) | (a << (16 - n));
        default: return a >> n;
    endcase
endfunction

function automatic expectT expectedOutcome(input instrT i, input logic [15:0] pc, ld);
    expectT      e;
    logic [15:0] a, b, s5, z5, s8, z8;
    a  = shadowRegs[i.rs];
    b  = shadowRegs[i.rt];
    s5 = {{11{i.rd[2]}}, i.rd, i.func};
    z5 = {11'd0, i.rd, i.func};
    s8 = {{8{i.rt[2]}}, i.rt, i.rd, i.func};
    z8 = {8'd0, i.rt, i.rd, i.func};
    e  = '0;
    e.checkResult = 1'b1;
    e.write       = 1'b1;
    e.writeReg    = i.rd;
    e.storeData   = b;
    case (i.opcode)
        OpRtype: e.result = arithOf(i.func, a, b);
        OpShift: e.result = shiftOf(i.func, a, b[3:0]);
        OpAddi, OpSubi, OpXori, OpAndni: begin
            e.result   = arithOf(i.opcode[1:0], a, i.opcode[1] ? z5 : s5);
            e.writeReg = i.rt;
        end
        OpRoli, OpSlli, OpRori, OpSrli: begin
            e.result   = shiftOf(i.opcode[1:0], a, z5[3:0]);
            e.writeReg = i.rt;
        end
        OpSeq: e.result = 16'(a == b);
        OpSlt: e.result = 16'($signed(a) < $signed(b));
        OpSle: e.result = 16'($signed(a) <= $signed(b));
        OpSlbi: begin
            e.result   = (a << 8) | z8;
            e.writeReg = i.rs;
        end
        OpLbi: begin
            e.result   = s8;
            e.writeReg = i.rs;
        end
        OpLd: begin
            e.result   = a + s5;
            e.memRead  = 1'b1;
            e.writeReg = i.rt;
        end
        OpSt: begin
            e.result   = a + s5;
            e.memWrite = 1'b1;
            e.write    = 1'b0;
        end
        OpJal: begin
            e.checkResult = 1'b0;
            e.writeReg    = 3'd7;
        end
        OpHalt: begin
            e.checkResult = 1'b0;
            e.write       = 1'b0;
            e.halt        = 1'b1;
        end
        OpNop: begin
            e.checkResult = 1'b0;
            e.write       = 1'b0;
        end
        default: begin
            e.checkResult = 1'b0;
            e.write       = 1'b0;
            e.err         = 1'b1;
        end
    endcase
    e.writeData = (i.opcode == OpLd) ? ld : ((i.opcode == OpJal) ? pc : e.result);
    return e;
endfunction

`endif

// File: tests/execCoreTb.sv
`timescale 1ns/1ns

module execCoreTb;
    import isaPkg::*;

    `include "execCoreRef.svh"

    localparam int HalfPeriod  = 10;
    localparam int ResetCycles = 10;
    localparam int ResetLimit  = 40;

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    instrT                instr;
    logic [DataWidth-1:0] incPc, loadData, aluResult, storeData;
    logic                 memRead, memWrite, halt, err;
    int                   seed = 7650;
    string                testName = "reset";
    expectT               want;
    logic [4:0]           badOps [12] = '{5'd2, 5'd3, 5'd4, 5'd5, 5'd7, 5'd12, 5'd13,
                                          5'd14, 5'd15, 5'd19, 5'd25, 5'd31};

    execCore uut (.*);

    always #HalfPeriod clk = ~clk;

    initial begin
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    task automatic reportMismatch(input string what, input logic [15:0] expected, actual);
        $display("Mismatch in test %s: %s expected %h, actual %h", testName, what, expected,
                 actual);
        $display("Simulation failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic issueInstr(input logic [4:0] op, input logic [2:0] rs, rt, rd,
                              input logic [1:0] func);
        @(negedge clk);
        instr    = {op, rs, rt, rd, func};
        incPc    = incPc + 16'd2;
        loadData = $random(seed);
    endtask

    task automatic issueImm5(input logic [4:0] op, input logic [2:0] rs, rt,
                             input logic [4:0] v);
        issueInstr(op, rs, rt, v[4:2], v[1:0]);
    endtask

    task automatic issueImm8(input logic [4:0] op, input logic [2:0] rs, input logic [7:0] v);
        issueInstr(op, rs, v[7:5], v[4:2], v[1:0]);
    endtask

    task automatic compareRegs(input logic [2:0] rs, rt);
        issueInstr(OpSeq, rs, rt, 3'd5, 2'd0);
        issueInstr(OpSlt, rs, rt, 3'd5, 2'd0);
        issueInstr(OpSle, rs, rt, 3'd5, 2'd0);
    endtask

    // ST with a zero offset shows a register on aluResult without writing anything.
    task automatic readAllRegs;
        for (int k = 0; k < RegCount; k++) begin
            issueInstr(OpSt, 3'(k), 3'(k), 3'd0, 2'd0);
        end
    endtask

    // outputs are settled one ns before the rising edge that retires the write.
    always @(negedge clk) begin
        #(HalfPeriod - 1);
        if (!reset) begin
            want = expectedOutcome(instr, incPc, loadData);
            assert (err === want.err) else reportMismatch("err", 16'(want.err), 16'(err));
            assert (halt === want.halt) else reportMismatch("halt", 16'(want.halt), 16'(halt));
            assert (memRead === want.memRead)
                else reportMismatch("memRead", 16'(want.memRead), 16'(memRead));
            assert (memWrite === want.memWrite)
                else reportMismatch("memWrite", 16'(want.memWrite), 16'(memWrite));
            assert (storeData === want.storeData)
                else reportMismatch("storeData", want.storeData, storeData);
            if (want.checkResult) begin
                assert (aluResult === want.result)
                    else reportMismatch("aluResult", want.result, aluResult);
            end
            if (want.write) begin
                shadowRegs[want.writeReg] = want.writeData;
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          n;
        instr    = {OpNop, 11'd0};
        incPc    = '0;
        loadData = '0;
        for (int k = 0; k < RegCount; k++) begin
            shadowRegs[k] = '0;
        end
        for (n = 0; reset && n < ResetLimit; n++) begin
            @(negedge clk);
        end
        if (reset) begin
            $display("reset was still high after %0d cycles", ResetLimit);
            $display("Simulation failed");
            $fatal(1, "reset timeout");
        end

        testName = "immediate loads";
        for (int k = 1; k <= 6; k++) begin
            issueImm8(OpLbi, 3'(k), 8'(k * 53));
            issueImm8(OpSlbi, 3'(k), 8'(250 - k * 29));
        end

        testName = "arithmetic and logic";
        for (int k = 0; k < RegCount; k++) begin
            issueImm8(OpLbi, 3'(k), 8'($random(seed)));
            issueImm8(OpSlbi, 3'(k), 8'($random(seed)));
        end
        for (int k = 0; k < 24; k++) begin
            r = $random(seed);
            issueInstr(OpRtype, r[2:0], r[5:3], r[8:6], r[10:9]);
            issueImm5(OpAddi | 5'(r[12:11]), r[8:6], r[15:13], r[20:16]); // reads rd back.
        end

        testName = "shifts and rotates";
        issueImm8(OpLbi, 3'd1, 8'h96);
        issueImm8(OpSlbi, 3'd1, 8'h3c);              // uneven pattern, every rotation differs.
        for (int amt = 0; amt < 16; amt++) begin
            issueImm8(OpLbi, 3'd2, 8'(amt));
            for (int f = 0; f < 4; f++) begin
                issueInstr(OpShift, 3'd1, 3'd2, 3'd3, 2'(f));
                issueImm5(OpRoli | 5'(f), 3'd1, 3'd4, 5'(amt));
            end
        end

        testName = "compares";
        issueImm8(OpLbi, 3'd1, 8'h80);
        issueImm8(OpSlbi, 3'd1, 8'h00);              // most negative value.
        issueImm8(OpLbi, 3'd2, 8'h7f);
        issueImm8(OpSlbi, 3'd2, 8'hff);
        issueImm8(OpLbi, 3'd3, 8'h7f);
        issueImm8(OpSlbi, 3'd3, 8'hff);
        compareRegs(3'd1, 3'd2);
        compareRegs(3'd2, 3'd1);
        compareRegs(3'd2, 3'd3);
        compareRegs(3'd1, 3'd1);
        for (int k = 0; k < 12; k++) begin
            r = $random(seed);
            compareRegs(r[2:0], r[5:3]);
        end

        testName = "memory and link";
        issueImm5(OpLd, 3'd1, 3'd5, 5'h1f);
        issueInstr(OpRtype, 3'd5, 3'd0, 3'd6, 2'd0);
        issueImm5(OpSt, 3'd2, 3'd5, 5'h04);
        issueInstr(OpJal, 3'd3, 3'd1, 3'd2, 2'd1);
        issueInstr(OpRtype, 3'd7, 3'd0, 3'd1, 2'd0);

        testName = "halt and errors";
        issueInstr(OpHalt, 3'd4, 3'd5, 3'd6, 2'd3);
        readAllRegs();
        foreach (badOps[k]) begin
            issueInstr(badOps[k], 3'd1, 3'd2, 3'(k), 2'd0);
        end
        readAllRegs();

        @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tests
design/isaPkg.sv
design/ctrlPkg.sv
design/controlUnit.sv
design/registerFile.sv
design/decode.sv
design/alu.sv
design/execCore.sv
tests/execCoreTb.sv
